//--- hdl/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Data path and instruction width
`define XLEN 32

// Architectural registers, x0 hardwired to zero
`define REG_COUNT 32

// Data RAM depth in words, indexed by address bits 7:2
`define DMEM_WORDS 64

`endif

//--- hdl/isa_pkg.sv
package isa_pkg;

	typedef enum logic [6:0] {
		OP_R      = 7'b0110011,
		OP_R_I    = 7'b0010011,
		OP_LUI    = 7'b0110111,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_BRANCH = 7'b1100011
	} opcode_e;

	// ALU and immediate-ALU funct3
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

	typedef enum logic [3:0] {
		ALU_ADD    = 4'b0000,
		ALU_SLT    = 4'b0001,
		ALU_SLTU   = 4'b0010,
		ALU_AND    = 4'b0011,
		ALU_OR     = 4'b0100,
		ALU_XOR    = 4'b0101,
		ALU_SLL    = 4'b0110,
		ALU_SRL    = 4'b0111,
		ALU_SUB    = 4'b1000,
		ALU_SRA    = 4'b1001,
		ALU_PASS_B = 4'b1010
	} alu_op_e;

	// Same values as the branch funct3
	typedef enum logic [2:0] {
		BR_EQ  = 3'b000,
		BR_NE  = 3'b001,
		BR_LT  = 3'b100,
		BR_GE  = 3'b101,
		BR_LTU = 3'b110,
		BR_GEU = 3'b111
	} br_cond_e;

	typedef enum logic [1:0] {
		MEM_FULL = 2'b00,
		MEM_HALF = 2'b01,
		MEM_BYTE = 2'b10
	} mem_size_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e    opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcode_e     opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		opcode_e    opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		opcode_e    opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		opcode_e     opcode;
	} u_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
	} instr_u;

endpackage

//--- hdl/pipe_pkg.sv
package pipe_pkg;

	`include "core_params.svh"

	typedef struct packed {
		isa_pkg::alu_op_e   alu_op;
		logic               use_imm;
		logic               reg_we;
		logic               mem_re;
		logic               mem_we;
		isa_pkg::mem_size_e mem_size;
		logic               mem_signed;
		logic               is_branch;
		isa_pkg::br_cond_e  br_cond;
		logic               illegal;
	} ctrl_t;

	// Decode to execute
	typedef struct packed {
		logic                           valid;
		ctrl_t                          ctrl;
		logic [$clog2(`REG_COUNT)-1:0]  rd;
		logic [`XLEN-1:0]               a;
		logic [`XLEN-1:0]               b;
		logic [`XLEN-1:0]               sd;
	} ex_req_t;

	// Execute to memory, result doubles as the address
	typedef struct packed {
		logic                           valid;
		ctrl_t                          ctrl;
		logic [$clog2(`REG_COUNT)-1:0]  rd;
		logic [`XLEN-1:0]               result;
		logic [`XLEN-1:0]               sd;
		logic                           br_taken;
	} mem_req_t;

	// Retire record, also used for forwarding
	typedef struct packed {
		logic                           valid;
		logic                           reg_we;
		logic [$clog2(`REG_COUNT)-1:0]  rd;
		logic [`XLEN-1:0]               data;
		logic                           is_branch;
		logic                           br_taken;
		logic                           illegal;
	} wb_t;

endpackage

//--- hdl/cpu_ctrl.sv
`timescale 1ns/1ps

module cpu_ctrl (
	input  isa_pkg::instr_u instr,
	output pipe_pkg::ctrl_t ctrl
);

	logic [2:0] f3;
	logic [6:0] f7;
	logic       f7_ok;
	logic       legal;
	pipe_pkg::ctrl_t c;

	function automatic isa_pkg::alu_op_e alu_sel(input logic [2:0] fn, input logic alt);
		isa_pkg::alu_op_e op;
		case (fn)
			isa_pkg::F3_ADD:  op = alt ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
			isa_pkg::F3_SLL:  op = isa_pkg::ALU_SLL;
			isa_pkg::F3_SLT:  op = isa_pkg::ALU_SLT;
			isa_pkg::F3_SLTU: op = isa_pkg::ALU_SLTU;
			isa_pkg::F3_XOR:  op = isa_pkg::ALU_XOR;
			isa_pkg::F3_SR:   op = alt ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
			isa_pkg::F3_OR:   op = isa_pkg::ALU_OR;
			default:          op = isa_pkg::ALU_AND;
		endcase
		return op;
	endfunction

	// Load and store width from funct3 low bits
	function automatic isa_pkg::mem_size_e size_sel(input logic [1:0] fn);
		isa_pkg::mem_size_e sz;
		case (fn)
			2'b00:   sz = isa_pkg::MEM_BYTE;
			2'b01:   sz = isa_pkg::MEM_HALF;
			default: sz = isa_pkg::MEM_FULL;
		endcase
		return sz;
	endfunction

	assign f3 = instr.r.funct3;
	assign f7 = instr.r.funct7;

	// Alternate funct7 only for SUB and SRA
	assign f7_ok = (f7 == isa_pkg::F7_BASE) ||
		(f7 == isa_pkg::F7_ALT && (f3 == isa_pkg::F3_ADD || f3 == isa_pkg::F3_SR));

	always_comb begin
		c.alu_op     = isa_pkg::ALU_ADD;
		c.use_imm    = 1'b0;
		c.reg_we     = 1'b0;
		c.mem_re     = 1'b0;
		c.mem_we     = 1'b0;
		c.mem_size   = isa_pkg::MEM_FULL;
		c.mem_signed = 1'b1;
		c.is_branch  = 1'b0;
		c.br_cond    = isa_pkg::BR_EQ;
		c.illegal    = 1'b0;
		legal        = 1'b0;
		case (instr.r.opcode)
			isa_pkg::OP_R: begin
				c.alu_op = alu_sel(f3, f7[5]);
				c.reg_we = 1'b1;
				legal    = f7_ok;
			end
			isa_pkg::OP_R_I: begin
				// Upper immediate bits are funct7 only for shifts
				c.alu_op  = alu_sel(f3, f7[5] && f3 == isa_pkg::F3_SR);
				c.use_imm = 1'b1;
				c.reg_we  = 1'b1;
				legal     = !(f3 == isa_pkg::F3_SLL || f3 == isa_pkg::F3_SR) || f7_ok;
			end
			isa_pkg::OP_LUI: begin
				c.alu_op  = isa_pkg::ALU_PASS_B;
				c.use_imm = 1'b1;
				c.reg_we  = 1'b1;
				legal     = 1'b1;
			end
			isa_pkg::OP_LOAD: begin
				c.use_imm    = 1'b1;
				c.reg_we     = 1'b1;
				c.mem_re     = 1'b1;
				c.mem_size   = size_sel(f3[1:0]);
				c.mem_signed = !f3[2];
				legal        = (f3[1:0] != 2'b11) && !(f3[2] && f3[1]);
			end
			isa_pkg::OP_STORE: begin
				c.use_imm  = 1'b1;
				c.mem_we   = 1'b1;
				c.mem_size = size_sel(f3[1:0]);
				legal      = !f3[2] && (f3[1:0] != 2'b11);
			end
			isa_pkg::OP_BRANCH: begin
				c.is_branch = 1'b1;
				c.br_cond   = isa_pkg::br_cond_e'(f3);
				legal       = (f3[2:1] != 2'b01);
			end
			default: legal = 1'b0;
		endcase
		if (!legal) begin
			c.reg_we    = 1'b0;
			c.mem_re    = 1'b0;
			c.mem_we    = 1'b0;
			c.is_branch = 1'b0;
		end
		c.illegal = !legal;
		ctrl      = c;
	end

endmodule

//--- hdl/id_stage.sv
`timescale 1ns/1ps

`include "core_params.svh"

module id_stage (
	input  logic              clk,
	input  logic              rst,
	input  logic              instr_valid,
	input  isa_pkg::instr_u   instr,
	input  pipe_pkg::wb_t     ex_fwd,
	input  pipe_pkg::wb_t     mem_fwd,
	input  pipe_pkg::wb_t     wb,
	output pipe_pkg::ex_req_t ex_req
);

	logic [`XLEN-1:0] regs [`REG_COUNT];
	logic [`XLEN-1:0] imm;
	logic [`XLEN-1:0] rs1_val;
	logic [`XLEN-1:0] rs2_val;
	pipe_pkg::ctrl_t   ctrl;
	pipe_pkg::ex_req_t ex_nxt;

	cpu_ctrl cpu_ctrl_i (
		.instr(instr),
		.ctrl (ctrl)
	);

	function automatic logic fwd_hit(input pipe_pkg::wb_t f,
		input logic [$clog2(`REG_COUNT)-1:0] rs);
		return f.valid && f.reg_we && f.rd == rs;
	endfunction

	// Youngest producer wins
	function automatic logic [`XLEN-1:0] read_op(input logic [$clog2(`REG_COUNT)-1:0] rs);
		logic [`XLEN-1:0] val;
		if (rs == '0) val = '0;
		else if (fwd_hit(ex_fwd, rs)) val = ex_fwd.data;
		else if (fwd_hit(mem_fwd, rs)) val = mem_fwd.data;
		else if (fwd_hit(wb, rs)) val = wb.data;
		else val = regs[rs];
		return val;
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid && wb.reg_we && wb.rd != '0) begin
			regs[wb.rd] <= wb.data;
		end
	end

	always_comb begin
		case (instr.r.opcode)
			isa_pkg::OP_STORE:
				imm = {{(`XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
			isa_pkg::OP_BRANCH:
				imm = {{(`XLEN-12){instr.b.imm_12}}, instr.b.imm_11, instr.b.imm_10_5,
					instr.b.imm_4_1, 1'b0};
			isa_pkg::OP_LUI:
				imm = {instr.u.imm, 12'b0};
			default:
				imm = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};
		endcase
	end

	always_comb begin
		rs1_val = read_op(instr.r.rs1);
		rs2_val = read_op(instr.r.rs2);
	end

	always_comb begin
		ex_nxt.valid = instr_valid;
		ex_nxt.ctrl  = ctrl;
		ex_nxt.rd    = instr.r.rd;
		ex_nxt.a     = rs1_val;
		ex_nxt.b     = ctrl.use_imm ? imm : rs2_val;
		ex_nxt.sd    = rs2_val;
	end

	always_ff @(posedge clk) begin
		ex_req <= ex_nxt;
		if (rst) begin
			ex_req.valid <= 1'b0;
		end
	end

endmodule

//--- hdl/ex_stage.sv
`timescale 1ns/1ps

`include "core_params.svh"

module ex_stage (
	input  logic               clk,
	input  logic               rst,
	input  pipe_pkg::ex_req_t  ex_req,
	output pipe_pkg::mem_req_t mem_req,
	output pipe_pkg::wb_t      ex_fwd
);

	logic [`XLEN-1:0]         a;
	logic [`XLEN-1:0]         b;
	logic [$clog2(`XLEN)-1:0] shamt;
	logic [`XLEN-1:0]         result;
	logic                     cmp;
	pipe_pkg::mem_req_t       mem_nxt;

	assign a     = ex_req.a;
	assign b     = ex_req.b;
	assign shamt = b[$clog2(`XLEN)-1:0];

	always_comb begin
		case (ex_req.ctrl.alu_op)
			isa_pkg::ALU_SUB:    result = a - b;
			isa_pkg::ALU_SLT:    result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			isa_pkg::ALU_SLTU:   result = {{(`XLEN-1){1'b0}}, a < b};
			isa_pkg::ALU_AND:    result = a & b;
			isa_pkg::ALU_OR:     result = a | b;
			isa_pkg::ALU_XOR:    result = a ^ b;
			isa_pkg::ALU_SLL:    result = a << shamt;
			isa_pkg::ALU_SRL:    result = a >> shamt;
			isa_pkg::ALU_SRA:    result = $signed(a) >>> shamt;
			isa_pkg::ALU_PASS_B: result = b;
			default:             result = a + b;
		endcase
	end

	always_comb begin
		case (ex_req.ctrl.br_cond)
			isa_pkg::BR_NE:  cmp = a != b;
			isa_pkg::BR_LT:  cmp = $signed(a) < $signed(b);
			isa_pkg::BR_GE:  cmp = $signed(a) >= $signed(b);
			isa_pkg::BR_LTU: cmp = a < b;
			isa_pkg::BR_GEU: cmp = a >= b;
			default:         cmp = a == b;
		endcase
	end

	always_comb begin
		mem_nxt.valid    = ex_req.valid;
		mem_nxt.ctrl     = ex_req.ctrl;
		mem_nxt.rd       = ex_req.rd;
		mem_nxt.result   = result;
		mem_nxt.sd       = ex_req.sd;
		mem_nxt.br_taken = ex_req.ctrl.is_branch && cmp;
	end

	// Load data is not ready here
	always_comb begin
		ex_fwd.valid     = ex_req.valid && !ex_req.ctrl.mem_re;
		ex_fwd.reg_we    = ex_req.ctrl.reg_we;
		ex_fwd.rd        = ex_req.rd;
		ex_fwd.data      = result;
		ex_fwd.is_branch = ex_req.ctrl.is_branch;
		ex_fwd.br_taken  = mem_nxt.br_taken;
		ex_fwd.illegal   = ex_req.ctrl.illegal;
	end

	always_ff @(posedge clk) begin
		mem_req <= mem_nxt;
		if (rst) begin
			mem_req.valid <= 1'b0;
		end
	end

endmodule

//--- hdl/mem_stage.sv
`timescale 1ns/1ps

`include "core_params.svh"

module mem_stage (
	input  logic               clk,
	input  logic               rst,
	input  pipe_pkg::mem_req_t mem_req,
	output pipe_pkg::wb_t      wb,
	output pipe_pkg::wb_t      mem_fwd
);

	logic [`XLEN-1:0]               ram [`DMEM_WORDS];
	logic [$clog2(`DMEM_WORDS)-1:0] idx;
	logic [1:0]                     lane;
	logic [`XLEN-1:0]               rword;
	logic [15:0]                    rhalf;
	logic [7:0]                     rbyte;
	logic [`XLEN-1:0]               load;
	logic [`XLEN/8-1:0]             be;
	logic [`XLEN-1:0]               wdata;
	pipe_pkg::wb_t                  wb_nxt;

	assign idx  = mem_req.result[$clog2(`DMEM_WORDS)+1:2];
	assign lane = mem_req.result[1:0];

	// Replicate store data so every lane sees it
	always_comb begin
		case (mem_req.ctrl.mem_size)
			isa_pkg::MEM_HALF: begin
				be    = lane[1] ? 4'b1100 : 4'b0011;
				wdata = {2{mem_req.sd[15:0]}};
			end
			isa_pkg::MEM_BYTE: begin
				be    = 4'b0001 << lane;
				wdata = {4{mem_req.sd[7:0]}};
			end
			default: begin
				be    = 4'b1111;
				wdata = mem_req.sd;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `DMEM_WORDS; i++) begin
				ram[i] <= '0;
			end
		end else if (mem_req.valid && mem_req.ctrl.mem_we) begin
			for (int k = 0; k < `XLEN/8; k++) begin
				if (be[k]) ram[idx][8*k +: 8] <= wdata[8*k +: 8];
			end
		end
	end

	assign rword = ram[idx];
	assign rhalf = lane[1] ? rword[31:16] : rword[15:0];
	assign rbyte = rword[8*lane +: 8];

	always_comb begin
		case (mem_req.ctrl.mem_size)
			isa_pkg::MEM_HALF:
				load = {{(`XLEN-16){mem_req.ctrl.mem_signed && rhalf[15]}}, rhalf};
			isa_pkg::MEM_BYTE:
				load = {{(`XLEN-8){mem_req.ctrl.mem_signed && rbyte[7]}}, rbyte};
			default:
				load = rword;
		endcase
	end

	always_comb begin
		wb_nxt.valid     = mem_req.valid;
		wb_nxt.reg_we    = mem_req.ctrl.reg_we;
		wb_nxt.rd        = mem_req.rd;
		wb_nxt.data      = mem_req.ctrl.mem_re ? load : mem_req.result;
		wb_nxt.is_branch = mem_req.ctrl.is_branch;
		wb_nxt.br_taken  = mem_req.br_taken;
		wb_nxt.illegal   = mem_req.ctrl.illegal;
	end

	assign mem_fwd = wb_nxt;

	always_ff @(posedge clk) begin
		wb <= wb_nxt;
		if (rst) begin
			wb.valid <= 1'b0;
		end
	end

endmodule

//--- hdl/cpu_pipe.sv
`timescale 1ns/1ps

`include "core_params.svh"

module cpu_pipe (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          instr_valid,
	input  logic [`XLEN-1:0]              instr,
	output logic                          wb_valid,
	output logic                          wb_we,
	output logic [$clog2(`REG_COUNT)-1:0] wb_rd,
	output logic [`XLEN-1:0]              wb_data,
	output logic                          br_valid,
	output logic                          br_taken,
	output logic                          illegal
);

	pipe_pkg::ex_req_t  ex_req;
	pipe_pkg::mem_req_t mem_req;
	pipe_pkg::wb_t      ex_fwd;
	pipe_pkg::wb_t      mem_fwd;
	pipe_pkg::wb_t      wb;

	id_stage id_stage_i (
		.clk        (clk),
		.rst        (rst),
		.instr_valid(instr_valid),
		.instr      (isa_pkg::instr_u'(instr)),
		.ex_fwd     (ex_fwd),
		.mem_fwd    (mem_fwd),
		.wb         (wb),
		.ex_req     (ex_req)
	);

	ex_stage ex_stage_i (
		.clk    (clk),
		.rst    (rst),
		.ex_req (ex_req),
		.mem_req(mem_req),
		.ex_fwd (ex_fwd)
	);

	mem_stage mem_stage_i (
		.clk    (clk),
		.rst    (rst),
		.mem_req(mem_req),
		.wb     (wb),
		.mem_fwd(mem_fwd)
	);

	assign wb_valid = wb.valid;
	assign wb_we    = wb.reg_we;
	assign wb_rd    = wb.rd;
	assign wb_data  = wb.data;
	// Flags qualified so they stay low while the pipe is empty
	assign br_valid = wb.valid && wb.is_branch;
	assign br_taken = wb.br_taken;
	assign illegal  = wb.valid && wb.illegal;

endmodule

//--- verif/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Expected retire record with the accepting clock edge
typedef struct packed {
	logic        we;
	logic [4:0]  rd;
	logic [31:0] data;
	logic        br;
	logic        taken;
	logic        ill;
	logic [31:0] acc_edge;
} retire_t;

logic [`XLEN-1:0] arch_regs [`REG_COUNT];
logic [`XLEN-1:0] arch_mem [`DMEM_WORDS];
logic [31:0]      lfsr = 32'h5a6a_9dc8;
// Destination of the previous load or zero
logic [4:0]       load_rd = '0;

function automatic void clear_model();
	for (int i = 0; i < `REG_COUNT; i++) begin
		arch_regs[i] = '0;
	end
	for (int i = 0; i < `DMEM_WORDS; i++) begin
		arch_mem[i] = '0;
	end
endfunction

// Galois LFSR stepped once per bit taken
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	r = '0;
	for (int k = 0; k < n; k++) begin
		r = {r[30:0], lfsr[0]};
		lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8000_0057 : lfsr >> 1;
	end
	return r;
endfunction

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
	input logic [31:0] a, input logic [31:0] b);
	logic [31:0] r;
	case (f3)
		3'd0: r = alt ? a - b : a + b;
		3'd1: r = a << b[4:0];
		3'd2: r = {31'b0, $signed(a) < $signed(b)};
		3'd3: r = {31'b0, a < b};
		3'd4: r = a ^ b;
		3'd5: begin
			if (alt) r = $signed(a) >>> b[4:0];
			else r = a >> b[4:0];
		end
		3'd6: r = a | b;
		default: r = a & b;
	endcase
	return r;
endfunction

// funct7 is zero or 0x20 for SUB and SRA
function automatic logic f7_ok(input logic [2:0] f3, input logic [6:0] f7);
	return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
endfunction

function automatic void store_ref(input logic [31:0] addr, input logic [2:0] f3,
	input logic [31:0] d);
	case (f3[1:0])
		2'd0: arch_mem[addr[7:2]][{addr[1:0], 3'b000} +: 8] = d[7:0];
		2'd1: arch_mem[addr[7:2]][{addr[1], 4'b0000} +: 16] = d[15:0];
		default: arch_mem[addr[7:2]] = d;
	endcase
endfunction

// Executes one instruction in program order and returns its retire record
function automatic retire_t execute_ref(input logic [31:0] w, input logic [31:0] acc);
	retire_t     e;
	logic [2:0]  f3;
	logic [6:0]  f7;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] addr;
	logic [31:0] word;
	logic [31:0] val;
	logic [7:0]  lane8;
	logic [15:0] lane16;
	logic        legal;
	f3 = w[14:12];
	f7 = w[31:25];
	a = arch_regs[w[19:15]];
	b = arch_regs[w[24:20]];
	e = '0;
	e.rd = w[11:7];
	e.acc_edge = acc;
	legal = 1'b1;
	val = '0;
	addr = '0;
	case (w[6:0])
		isa_pkg::OP_R: begin
			legal = f7_ok(f3, f7);
			val = alu_ref(f3, f7[5], a, b);
			e.we = 1'b1;
		end
		isa_pkg::OP_R_I: begin
			if (f3 == 3'd1 || f3 == 3'd5) legal = f7_ok(f3, f7);
			val = alu_ref(f3, f3 == 3'd5 && f7[5], a, {{20{w[31]}}, w[31:20]});
			e.we = 1'b1;
		end
		isa_pkg::OP_LUI: begin
			val = {w[31:12], 12'b0};
			e.we = 1'b1;
		end
		isa_pkg::OP_LOAD: begin
			legal = f3 != 3'd3 && f3[2:1] != 2'b11;
			addr = a + {{20{w[31]}}, w[31:20]};
			word = arch_mem[addr[7:2]];
			lane8 = word[{addr[1:0], 3'b000} +: 8];
			lane16 = word[{addr[1], 4'b0000} +: 16];
			case (f3[1:0])
				2'd0: val = {{24{lane8[7] & ~f3[2]}}, lane8};
				2'd1: val = {{16{lane16[15] & ~f3[2]}}, lane16};
				default: val = word;
			endcase
			e.we = 1'b1;
		end
		isa_pkg::OP_STORE: begin
			legal = !f3[2] && f3[1:0] != 2'b11;
			addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
		end
		isa_pkg::OP_BRANCH: begin
			legal = f3[2:1] != 2'b01;
			e.br = 1'b1;
			case (f3)
				3'd0: e.taken = a == b;
				3'd1: e.taken = a != b;
				3'd4: e.taken = $signed(a) < $signed(b);
				3'd5: e.taken = $signed(a) >= $signed(b);
				3'd6: e.taken = a < b;
				default: e.taken = a >= b;
			endcase
		end
		default: legal = 1'b0;
	endcase
	if (!legal) begin
		e.we = 1'b0;
		e.br = 1'b0;
		e.taken = 1'b0;
		e.ill = 1'b1;
	end else if (w[6:0] == isa_pkg::OP_STORE) begin
		store_ref(addr, f3, b);
	end else if (e.we && e.rd != '0) begin
		arch_regs[e.rd] = val;
	end
	e.data = val;
	return e;
endfunction

// Registers x0..x7 only so dependencies come often
function automatic logic [31:0] gen_instr();
	logic [2:0]  cls;
	logic [2:0]  kind;
	logic [4:0]  rd;
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [2:0]  f3;
	logic [6:0]  f7;
	logic [11:0] imm;
	logic [31:0] w;
	cls = 3'(rand_bits(3));
	rd = 5'(rand_bits(3));
	rs1 = 5'(rand_bits(3));
	rs2 = 5'(rand_bits(3));
	f3 = 3'(rand_bits(3));
	f7 = rand_bits(1) != 0 ? 7'h20 : 7'h00;
	imm = 12'(rand_bits(12));
	// Keep memory ops near address zero so loads hit earlier stores
	if (cls == 3'd4 || cls == 3'd5 || cls == 3'd7) begin
		if (rand_bits(1) != 0) rs1 = '0;
		imm = 12'(rand_bits(5));
	end
	// No load result read by the very next instruction
	if (load_rd != '0 && rs1 == load_rd) rs1 = rs1 ^ 5'd1;
	if (load_rd != '0 && rs2 == load_rd) rs2 = rs2 ^ 5'd1;
	case (cls)
		3'd0, 3'd1: begin
			if (f3 != 3'd0 && f3 != 3'd5) f7 = 7'h00;
			w = {f7, rs2, rs1, f3, rd, isa_pkg::OP_R};
		end
		3'd2: begin
			if (f3 == 3'd1) imm[11:5] = 7'h00;
			if (f3 == 3'd5) imm[11:5] = f7;
			w = {imm, rs1, f3, rd, isa_pkg::OP_R_I};
		end
		3'd3: w = {imm, rs1, f3, rd, isa_pkg::OP_LUI};
		3'd4: begin
			if (f3 == 3'd3 || f3[2:1] == 2'b11) f3 = 3'd2;
			w = {imm, rs1, f3, rd, isa_pkg::OP_LOAD};
		end
		3'd5: begin
			f3 = {1'b0, f3[1:0] == 2'b11 ? 2'b10 : f3[1:0]};
			w = {imm[11:5], rs2, rs1, f3, imm[4:0], isa_pkg::OP_STORE};
		end
		3'd6: begin
			if (f3[2:1] == 2'b01) f3 = f3 ^ 3'b110;
			w = {imm[11:5], rs2, rs1, f3, imm[4:0], isa_pkg::OP_BRANCH};
		end
		default: begin
			kind = 3'(rand_bits(3));
			case (kind)
				3'd0: w = {imm, rs1, f3, rd, 7'b0001111};
				3'd1: w = {7'h01, rs2, rs1, f3, rd, isa_pkg::OP_R};
				3'd2: w = {imm, rs1, 3'd3, rd, isa_pkg::OP_LOAD};
				3'd3: w = {imm, rs1, {2'b11, f3[0]}, rd, isa_pkg::OP_LOAD};
				3'd4: w = {imm[11:5], rs2, rs1, {1'b1, f3[1:0]}, imm[4:0], isa_pkg::OP_STORE};
				3'd5: w = {imm[11:5], rs2, rs1, 3'd3, imm[4:0], isa_pkg::OP_STORE};
				3'd6: w = {7'h20, imm[4:0], rs1, 3'd1, rd, isa_pkg::OP_R_I};
				default: w = {imm[11:5], rs2, rs1, {2'b01, f3[0]}, imm[4:0], isa_pkg::OP_BRANCH};
			endcase
		end
	endcase
	load_rd = w[6:0] == isa_pkg::OP_LOAD ? rd : '0;
	return w;
endfunction

`endif

//--- verif/tb_cpu_pipe.sv
`timescale 1ns/1ps

`include "core_params.svh"

module tb_cpu_pipe;

	localparam int N_INSTR = 400;

	logic                          clk;
	logic                          rst;
	logic                          instr_valid;
	logic [`XLEN-1:0]              instr;
	logic                          wb_valid;
	logic                          wb_we;
	logic [$clog2(`REG_COUNT)-1:0] wb_rd;
	logic [`XLEN-1:0]              wb_data;
	logic                          br_valid;
	logic                          br_taken;
	logic                          illegal;
	logic [31:0]                   edge_cnt = '0;

	`include "tb_model.svh"

	retire_t expected [$];

	cpu_pipe cpu_pipe_i (
		.clk        (clk),
		.rst        (rst),
		.instr_valid(instr_valid),
		.instr      (instr),
		.wb_valid   (wb_valid),
		.wb_we      (wb_we),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data),
		.br_valid   (br_valid),
		.br_taken   (br_taken),
		.illegal    (illegal)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		edge_cnt <= edge_cnt + 32'd1;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	// Outputs sampled on the falling edge halfway between updates
	task automatic check_retire();
		retire_t exp;
		if (!wb_valid) begin
			assert (br_valid === 1'b0 && illegal === 1'b0)
			else fail_run("br_valid or illegal went high while wb_valid was low");
		end else if (expected.size() == 0) begin
			fail_run("wb_valid went high with no instruction outstanding");
		end else begin
			exp = expected.pop_front();
			assert (edge_cnt == exp.acc_edge + 32'd2)
			else fail_run($sformatf(
				"Retire seen after edge %0d for an instruction accepted at edge %0d",
				edge_cnt, exp.acc_edge));
			check_value("wb_we", 32'(wb_we), 32'(exp.we));
			if (exp.we) begin
				check_value("wb_rd", 32'(wb_rd), 32'(exp.rd));
				check_value("wb_data", wb_data, exp.data);
			end
			check_value("br_valid", 32'(br_valid), 32'(exp.br));
			if (exp.br) check_value("br_taken", 32'(br_taken), 32'(exp.taken));
			check_value("illegal", 32'(illegal), 32'(exp.ill));
		end
	endtask

	task automatic step_cycle(input logic valid, input logic [31:0] word);
		retire_t exp;
		check_retire();
		instr_valid = valid;
		instr = word;
		if (valid) begin
			exp = execute_ref(word, edge_cnt + 32'd1);
			expected.push_back(exp);
		end
		@(negedge clk);
	endtask

	initial begin
		logic [31:0] word;
		int          gap;
		clk = 1'b0;
		rst = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		clear_model();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int n = 0; n < N_INSTR; n++) begin
			gap = rand_bits(2) == 0 ? int'(rand_bits(2)) : 0;
			repeat (gap) step_cycle(1'b0, '0);
			word = gen_instr();
			step_cycle(1'b1, word);
		end
		// Three stages to drain plus margin
		repeat (8) step_cycle(1'b0, '0);
		if (expected.size() == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			fail_run($sformatf("%0d instructions never retired", expected.size()));
		end
	end

	// Two cycles per instruction leaves room over the average gap
	initial begin
		#((N_INSTR + 20) * 8 * 2);
		fail_run("Timeout before all instructions retired");
	end

endmodule

//--- sim.f
+incdir+hdl
+incdir+verif
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/cpu_ctrl.sv
hdl/id_stage.sv
hdl/ex_stage.sv
hdl/mem_stage.sv
hdl/cpu_pipe.sv
verif/tb_cpu_pipe.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator and run; exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sim.f --top-module tb_cpu_pipe -o tb_cpu_pipe &&
./obj_dir/tb_cpu_pipe || exit 1
